/* Bender.yml */
package:
  name: i2c_master

sources:
  - hdl/i2c_pkg.sv
  - hdl/i2c_bit_ctl.sv
  - hdl/i2c_byte_ctl.sv
  - hdl/i2c_master_top.sv
  - target: test
    files:
      - verif/tb_clk_gen.sv
      - verif/i2c_slave_model.sv
      - verif/tb_i2c_master.sv

/* hdl/i2c_bit_ctl.sv */
`default_nettype none

module i2c_bit_ctl
(
    input  logic                           i_sysclk,
    input  logic                           i_nReset,
    input  logic                           i_enable,
    input  logic [i2c_pkg::PRESCALE_W-1:0] i_prescale,   // phase tick rate
    input  logic [i2c_pkg::PRESCALE_W-1:0] i_dfsr,       // sda sample rate
    input  i2c_pkg::bit_cmd_e              i_cmd,
    input  logic                           i_din,
    input  logic                           i_scl,
    input  logic                           i_sda,
    output logic                           o_cmd_ack,
    output logic                           o_busy,
    output logic                           o_arblost,
    output logic                           o_dout,
    output logic                           o_scl_oen,
    output logic                           o_sda_oen
);

    i2c_pkg::bit_state_e             s_state;
    logic [i2c_pkg::PRESCALE_W-1:0]  s_cnt;
    logic [i2c_pkg::PRESCALE_W-1:0]  s_filter_cnt;
    logic                            s_clk_en;
    logic                            s_sda_chk;
    logic                            s_sda;

    always_ff @(posedge i_sysclk or negedge i_nReset)
    begin
        if (!i_nReset)
        begin
            s_cnt        <= i2c_pkg::RESET_PRESCALE;
            s_filter_cnt <= i2c_pkg::RESET_PRESCALE >> 4;
            s_clk_en     <= 1'b1;
            s_sda        <= 1'b0;
        end
        else if (!i_enable)
        begin
            s_cnt        <= i_prescale >> 2;
            s_filter_cnt <= i_dfsr >> 1;
            s_clk_en     <= 1'b1;
            s_sda        <= 1'b0;
        end
        else
        begin
            if (s_cnt == '0)
            begin
                // idle polls commands four times faster
                if (s_state == i2c_pkg::B_IDLE)
                    s_cnt <= i_prescale >> 4;
                else
                    s_cnt <= i_prescale >> 2;
                s_clk_en <= 1'b1;
            end
            else
            begin
                s_cnt    <= s_cnt - 1'b1;
                s_clk_en <= 1'b0;
            end

            if (s_filter_cnt == '0)
            begin
                s_filter_cnt <= i_dfsr >> 1;
                if (o_sda_oen && i_scl)
                    s_sda <= i_sda;             // sda only counts with scl high
            end
            else
                s_filter_cnt <= s_filter_cnt - 1'b1;
        end
    end

    always_ff @(posedge i_sysclk or negedge i_nReset)
    begin
        if (!i_nReset)
        begin
            s_state   <= i2c_pkg::B_IDLE;
            s_sda_chk <= 1'b0;
            o_cmd_ack <= 1'b0;
            o_busy    <= 1'b0;
            o_arblost <= 1'b0;
            o_scl_oen <= 1'b1;
            o_sda_oen <= 1'b1;
        end
        else if (!i_enable)
        begin
            s_state   <= i2c_pkg::B_IDLE;
            s_sda_chk <= 1'b0;
            o_cmd_ack <= 1'b0;
            o_busy    <= 1'b0;
            o_arblost <= 1'b0;
            o_scl_oen <= 1'b1;
            o_sda_oen <= 1'b1;
        end
        else
        begin
            o_cmd_ack <= 1'b0;
            if (s_clk_en)
            begin
                s_sda_chk <= 1'b0;
                if (s_sda_chk && o_sda_oen && !s_sda)
                    o_arblost <= 1'b1;          // released, yet held low by another master
                case (s_state)
                    i2c_pkg::B_IDLE:
                    begin
                        case (i_cmd)
                            i2c_pkg::CMD_START:   s_state <= i2c_pkg::B_START_A;
                            i2c_pkg::CMD_STOP:    s_state <= i2c_pkg::B_STOP_A;
                            i2c_pkg::CMD_WRITE:   s_state <= i2c_pkg::B_WRITE_A;
                            i2c_pkg::CMD_READ:    s_state <= i2c_pkg::B_READ_A;
                            i2c_pkg::CMD_RESTART: s_state <= i2c_pkg::B_RESTART_A;
                            default:              s_state <= i2c_pkg::B_IDLE;
                        endcase
                    end
                    i2c_pkg::B_START_A:
                    begin
                        s_state   <= i2c_pkg::B_START_B;
                        o_sda_oen <= 1'b1;
                    end
                    i2c_pkg::B_START_B:
                    begin
                        s_state   <= i2c_pkg::B_START_C;
                        o_scl_oen <= 1'b1;
                        o_sda_oen <= 1'b1;
                    end
                    i2c_pkg::B_START_C:
                    begin
                        s_state   <= i2c_pkg::B_START_D;
                        o_sda_oen <= 1'b0;              // start condition
                    end
                    i2c_pkg::B_START_D: s_state <= i2c_pkg::B_START_E;
                    i2c_pkg::B_START_E:
                    begin
                        s_state   <= i2c_pkg::B_IDLE;
                        o_cmd_ack <= 1'b1;
                        o_busy    <= 1'b1;
                        o_scl_oen <= 1'b0;
                    end
                    i2c_pkg::B_STOP_A:
                    begin
                        s_state   <= i2c_pkg::B_STOP_B;
                        o_scl_oen <= 1'b0;
                        o_sda_oen <= 1'b0;
                    end
                    i2c_pkg::B_STOP_B:
                    begin
                        s_state   <= i2c_pkg::B_STOP_C;
                        o_scl_oen <= 1'b1;
                    end
                    i2c_pkg::B_STOP_C:
                    begin
                        s_state   <= i2c_pkg::B_STOP_D;
                        o_sda_oen <= 1'b1;              // stop condition
                        s_sda_chk <= 1'b1;
                    end
                    i2c_pkg::B_STOP_D:
                    begin
                        s_state   <= i2c_pkg::B_IDLE;
                        o_cmd_ack <= 1'b1;
                        o_busy    <= 1'b0;
                    end
                    i2c_pkg::B_READ_A:
                    begin
                        s_state   <= i2c_pkg::B_READ_B;
                        o_scl_oen <= 1'b0;
                        o_sda_oen <= 1'b1;
                    end
                    i2c_pkg::B_READ_B:
                    begin
                        s_state   <= i2c_pkg::B_READ_C;
                        o_scl_oen <= 1'b1;
                    end
                    i2c_pkg::B_READ_C: s_state <= i2c_pkg::B_READ_D;
                    i2c_pkg::B_READ_D:
                    begin
                        s_state   <= i2c_pkg::B_IDLE;
                        o_cmd_ack <= 1'b1;
                        o_scl_oen <= 1'b0;
                    end
                    i2c_pkg::B_WRITE_A:
                    begin
                        s_state   <= i2c_pkg::B_WRITE_B;
                        o_scl_oen <= 1'b0;
                        o_sda_oen <= i_din;
                    end
                    i2c_pkg::B_WRITE_B:
                    begin
                        s_state   <= i2c_pkg::B_WRITE_C;
                        o_scl_oen <= 1'b1;
                        o_sda_oen <= i_din;
                    end
                    i2c_pkg::B_WRITE_C:
                    begin
                        s_state   <= i2c_pkg::B_WRITE_D;
                        o_sda_oen <= i_din;
                        s_sda_chk <= 1'b1;
                    end
                    i2c_pkg::B_WRITE_D:
                    begin
                        s_state   <= i2c_pkg::B_IDLE;
                        o_cmd_ack <= 1'b1;
                        o_scl_oen <= 1'b0;
                        o_sda_oen <= i_din;
                    end
                    i2c_pkg::B_RESTART_A:
                    begin
                        s_state   <= i2c_pkg::B_RESTART_B;
                        o_scl_oen <= 1'b0;
                        o_sda_oen <= 1'b1;
                    end
                    i2c_pkg::B_RESTART_B:
                    begin
                        s_state   <= i2c_pkg::B_RESTART_C;
                        o_scl_oen <= 1'b1;
                        s_sda_chk <= 1'b1;              // bus must be free before pulling sda
                    end
                    i2c_pkg::B_RESTART_C:
                    begin
                        s_state   <= i2c_pkg::B_RESTART_D;
                        o_sda_oen <= 1'b0;
                    end
                    i2c_pkg::B_RESTART_D:
                    begin
                        s_state   <= i2c_pkg::B_IDLE;
                        o_cmd_ack <= 1'b1;
                        o_scl_oen <= 1'b0;
                    end
                    default: s_state <= i2c_pkg::B_IDLE;
                endcase
            end
        end
    end

    assign o_dout = s_sda;

    a_ack_single: assert property (@(posedge i_sysclk) disable iff (!i_nReset)
        o_cmd_ack |=> !o_cmd_ack);

    a_idle_when_off: assert property (@(posedge i_sysclk) disable iff (!i_nReset)
        !i_enable |=> s_state == i2c_pkg::B_IDLE);

endmodule

`default_nettype wire

/* hdl/i2c_byte_ctl.sv */
`default_nettype none

module i2c_byte_ctl
(
    input  logic                        i_sysclk,
    input  logic                        i_nReset,
    input  logic                        i_enable,
    input  logic                        i_start,
    input  logic                        i_stop,
    input  logic                        i_read,
    input  logic                        i_write,
    input  logic                        i_ack_in,     // level sent after a read
    input  logic [i2c_pkg::DATA_W-1:0]  i_txd,
    input  logic                        i_bit_ack,
    input  logic                        i_bit_dout,
    input  logic                        i_arblost,
    output i2c_pkg::bit_cmd_e           o_bit_cmd,
    output logic                        o_bit_din,
    output logic                        o_done,
    output logic                        o_ack_out,
    output logic [i2c_pkg::DATA_W-1:0]  o_rxd
);

    i2c_pkg::byte_state_e              s_state;
    logic [i2c_pkg::DATA_W-1:0]        s_sr;
    logic [i2c_pkg::BIT_CNT_W-1:0]     s_bit_cnt;
    logic                              s_open;      // start sent, no stop yet
    logic                              s_accept;

    // new strobes are ignored in the done cycle, the caller is still clearing them
    assign s_accept = (s_state == i2c_pkg::ST_IDLE) && !o_done;

    always_ff @(posedge i_sysclk)
    begin
        if (s_accept && (i_start || i_write))
            s_sr <= i_txd;
        else if (i_bit_ack && (s_state == i2c_pkg::ST_WRITE || s_state == i2c_pkg::ST_READ))
            s_sr <= {s_sr[i2c_pkg::DATA_W-2:0], i_bit_dout};   // msb first both ways
    end

    always_ff @(posedge i_sysclk or negedge i_nReset)
    begin
        if (!i_nReset)
        begin
            s_state   <= i2c_pkg::ST_IDLE;
            s_bit_cnt <= '1;
            s_open    <= 1'b0;
            o_bit_cmd <= i2c_pkg::CMD_IDLE;
            o_bit_din <= 1'b1;
            o_done    <= 1'b0;
            o_ack_out <= 1'b0;
        end
        else if (!i_enable)
        begin
            s_state   <= i2c_pkg::ST_IDLE;
            s_bit_cnt <= '1;
            s_open    <= 1'b0;
            o_bit_cmd <= i2c_pkg::CMD_IDLE;
            o_bit_din <= 1'b1;
            o_done    <= 1'b0;
            o_ack_out <= 1'b0;
        end
        else
        begin
            o_done <= 1'b0;
            if (i_arblost && s_state != i2c_pkg::ST_IDLE)
            begin
                s_state   <= i2c_pkg::ST_IDLE;      // give up the byte
                s_open    <= 1'b0;
                o_bit_cmd <= i2c_pkg::CMD_IDLE;
                o_done    <= 1'b1;
            end
            else if (s_state == i2c_pkg::ST_IDLE)
            begin
                s_bit_cnt <= '1;
                if (s_accept && i_start)
                begin
                    s_state   <= i2c_pkg::ST_START;
                    o_bit_cmd <= s_open ? i2c_pkg::CMD_RESTART : i2c_pkg::CMD_START;
                end
                else if (s_accept && i_write)
                begin
                    s_state   <= i2c_pkg::ST_WRITE;
                    o_bit_cmd <= i2c_pkg::CMD_WRITE;
                    o_bit_din <= i_txd[i2c_pkg::DATA_W-1];
                end
                else if (s_accept && i_read)
                begin
                    s_state   <= i2c_pkg::ST_READ;
                    o_bit_cmd <= i2c_pkg::CMD_READ;
                    o_bit_din <= 1'b1;
                end
                else if (s_accept && i_stop)
                begin
                    s_state   <= i2c_pkg::ST_STOP;
                    o_bit_cmd <= i2c_pkg::CMD_STOP;
                end
            end
            else if (i_bit_ack)
            begin
                case (s_state)
                    i2c_pkg::ST_START:
                    begin
                        s_open <= 1'b1;
                        if (i_write)
                        begin
                            s_state   <= i2c_pkg::ST_WRITE;
                            o_bit_cmd <= i2c_pkg::CMD_WRITE;
                            o_bit_din <= s_sr[i2c_pkg::DATA_W-1];
                        end
                        else if (i_read)
                        begin
                            s_state   <= i2c_pkg::ST_READ;
                            o_bit_cmd <= i2c_pkg::CMD_READ;
                            o_bit_din <= 1'b1;
                        end
                        else
                        begin
                            s_state   <= i2c_pkg::ST_IDLE;
                            o_bit_cmd <= i2c_pkg::CMD_IDLE;
                            o_done    <= 1'b1;
                        end
                    end
                    i2c_pkg::ST_WRITE:
                    begin
                        if (s_bit_cnt == '0)
                        begin
                            s_state   <= i2c_pkg::ST_ACK;
                            o_bit_cmd <= i2c_pkg::CMD_READ;    // slave ack
                            o_bit_din <= 1'b1;
                        end
                        else
                        begin
                            s_bit_cnt <= s_bit_cnt - 1'b1;
                            o_bit_din <= s_sr[i2c_pkg::DATA_W-2];
                        end
                    end
                    i2c_pkg::ST_READ:
                    begin
                        if (s_bit_cnt == '0)
                        begin
                            s_state   <= i2c_pkg::ST_ACK;
                            o_bit_cmd <= i2c_pkg::CMD_WRITE;
                            o_bit_din <= i_ack_in;
                        end
                        else
                            s_bit_cnt <= s_bit_cnt - 1'b1;
                    end
                    i2c_pkg::ST_ACK:
                    begin
                        if (o_bit_cmd == i2c_pkg::CMD_READ)
                            o_ack_out <= i_bit_dout;
                        if (i_stop)
                        begin
                            s_state   <= i2c_pkg::ST_STOP;
                            o_bit_cmd <= i2c_pkg::CMD_STOP;
                        end
                        else
                        begin
                            s_state   <= i2c_pkg::ST_IDLE;
                            o_bit_cmd <= i2c_pkg::CMD_IDLE;
                            o_done    <= 1'b1;
                        end
                    end
                    i2c_pkg::ST_STOP:
                    begin
                        s_state   <= i2c_pkg::ST_IDLE;
                        s_open    <= 1'b0;
                        o_bit_cmd <= i2c_pkg::CMD_IDLE;
                        o_done    <= 1'b1;
                    end
                    default: s_state <= i2c_pkg::ST_IDLE;
                endcase
            end
        end
    end

    assign o_rxd = s_sr;

    a_done_after_work: assert property (@(posedge i_sysclk) disable iff (!i_nReset)
        o_done |-> $past(s_state) != i2c_pkg::ST_IDLE);

endmodule

`default_nettype wire

/* hdl/i2c_master_top.sv */
`default_nettype none

module i2c_master_top
(
    input  logic                           i_sysclk,
    input  logic                           i_nReset,
    input  logic                           i_enable,
    input  logic [i2c_pkg::PRESCALE_W-1:0] i_prescale,
    input  logic [i2c_pkg::PRESCALE_W-1:0] i_dfsr,
    input  logic                           i_start,
    input  logic                           i_stop,
    input  logic                           i_read,
    input  logic                           i_write,
    input  logic                           i_ack_in,
    input  logic [i2c_pkg::DATA_W-1:0]     i_txd,
    input  logic                           i_scl,
    input  logic                           i_sda,
    output logic                           o_done,
    output logic [i2c_pkg::DATA_W-1:0]     o_rxd,
    output logic                           o_ack_out,
    output logic                           o_busy,
    output logic                           o_arblost,
    output logic                           o_scl,
    output logic                           o_scl_oen,
    output logic                           o_sda,
    output logic                           o_sda_oen
);

    i2c_pkg::bit_cmd_e  s_bit_cmd;
    logic               s_bit_din;
    logic               s_bit_ack;
    logic               s_bit_dout;

    i2c_byte_ctl u_byte_ctl
    (
        .i_sysclk   (i_sysclk),
        .i_nReset   (i_nReset),
        .i_enable   (i_enable),
        .i_start    (i_start),
        .i_stop     (i_stop),
        .i_read     (i_read),
        .i_write    (i_write),
        .i_ack_in   (i_ack_in),
        .i_txd      (i_txd),
        .i_bit_ack  (s_bit_ack),
        .i_bit_dout (s_bit_dout),
        .i_arblost  (o_arblost),
        .o_bit_cmd  (s_bit_cmd),
        .o_bit_din  (s_bit_din),
        .o_done     (o_done),
        .o_ack_out  (o_ack_out),
        .o_rxd      (o_rxd)
    );

    i2c_bit_ctl u_bit_ctl
    (
        .i_sysclk   (i_sysclk),
        .i_nReset   (i_nReset),
        .i_enable   (i_enable),
        .i_prescale (i_prescale),
        .i_dfsr     (i_dfsr),
        .i_cmd      (s_bit_cmd),
        .i_din      (s_bit_din),
        .i_scl      (i_scl),
        .i_sda      (i_sda),
        .o_cmd_ack  (s_bit_ack),
        .o_busy     (o_busy),
        .o_arblost  (o_arblost),
        .o_dout     (s_bit_dout),
        .o_scl_oen  (o_scl_oen),
        .o_sda_oen  (o_sda_oen)
    );

    // pad data follows the enable, the pad itself only ever pulls low
    assign o_scl = o_scl_oen;
    assign o_sda = o_sda_oen;

endmodule

`default_nettype wire

/* hdl/i2c_pkg.sv */
`default_nettype none

package i2c_pkg;

    localparam int PRESCALE_W = 16;                 // prescale and sample-rate inputs
    localparam int DATA_W     = 8;
    localparam int BIT_CNT_W  = $clog2(DATA_W);      // bit counter in the byte sequencer
    localparam logic [PRESCALE_W-1:0] RESET_PRESCALE = 16'd192;

    // bit level commands, byte controller to bit controller
    typedef enum logic [2:0] {
        CMD_IDLE    = 3'd0,
        CMD_START   = 3'd1,
        CMD_STOP    = 3'd2,
        CMD_WRITE   = 3'd3,
        CMD_READ    = 3'd4,
        CMD_RESTART = 3'd5
    } bit_cmd_e;

    typedef enum logic [4:0] {
        B_IDLE,
        B_START_A,
        B_START_B,
        B_START_C,
        B_START_D,
        B_START_E,
        B_STOP_A,
        B_STOP_B,
        B_STOP_C,
        B_STOP_D,
        B_READ_A,
        B_READ_B,
        B_READ_C,
        B_READ_D,
        B_WRITE_A,
        B_WRITE_B,
        B_WRITE_C,
        B_WRITE_D,
        B_RESTART_A,
        B_RESTART_B,
        B_RESTART_C,
        B_RESTART_D
    } bit_state_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_START,
        ST_WRITE,
        ST_READ,
        ST_ACK,     // ninth bit, either direction
        ST_STOP
    } byte_state_e;

endpackage

`default_nettype wire

/* sim.f */
hdl/i2c_pkg.sv
hdl/i2c_bit_ctl.sv
hdl/i2c_byte_ctl.sv
hdl/i2c_master_top.sv
verif/tb_clk_gen.sv
verif/i2c_slave_model.sv
verif/tb_i2c_master.sv

/* verif/i2c_slave_model.sv */
`default_nettype none

module i2c_slave_model
#(
    parameter logic [6:0] ADDR    = 7'h2C,
    parameter logic [7:0] RD_BYTE = 8'hA5
)
(
    input  logic       i_scl,
    input  logic       i_sda,
    input  logic       i_force_low,     // pull sda low whatever the protocol says
    output logic       o_sda_low,
    output logic [7:0] o_rx_byte,
    output int         o_rx_count
);
    timeunit 1ns;
    timeprecision 100ps;

    typedef enum {P_IDLE, P_ADDR, P_WRITE, P_READ} phase_e;

    phase_e     phase;
    logic [7:0] sr;
    int         bit_cnt;                // rising scl edges in this byte
    logic       mst_nack;
    logic       drive_low;

    initial
    begin
        phase      = P_IDLE;
        sr         = '0;
        bit_cnt    = 0;
        mst_nack   = 1'b1;
        drive_low  = 1'b0;
        o_rx_byte  = '0;
        o_rx_count = 0;
    end

    assign o_sda_low = drive_low | i_force_low;

    // start or repeated start
    always @(negedge i_sda)
    begin
        if (i_scl === 1'b1)
        begin
            phase     = P_ADDR;
            bit_cnt   = 0;
            drive_low = 1'b0;
        end
    end

    always @(posedge i_sda)
    begin
        if (i_scl === 1'b1)
        begin
            phase     = P_IDLE;         // stop
            drive_low = 1'b0;
        end
    end

    always @(posedge i_scl)
    begin
        if (phase != P_IDLE)
        begin
            if (bit_cnt < 8)
                sr = {sr[6:0], i_sda};
            else
                mst_nack = i_sda;       // ninth bit from the master
            bit_cnt++;
        end
    end

    // sda only changes while scl is low
    always @(negedge i_scl)
    begin
        if (phase != P_IDLE && bit_cnt == 8)
        begin
            if (phase == P_READ)
                drive_low = 1'b0;       // master answers
            else if (phase == P_WRITE || sr[7:1] == ADDR)
                drive_low = 1'b1;
            else
                phase = P_IDLE;         // not our address
            if (phase == P_WRITE)
            begin
                o_rx_byte = sr;
                o_rx_count++;
            end
        end
        else if (phase != P_IDLE && bit_cnt == 9)
        begin
            bit_cnt = 0;
            if (phase == P_ADDR)
                phase = sr[0] ? P_READ : P_WRITE;
            else if (phase == P_READ && mst_nack)
                phase = P_IDLE;
            drive_low = (phase == P_READ) ? !RD_BYTE[7] : 1'b0;
        end
        else if (phase == P_READ && bit_cnt > 0)
            drive_low = !RD_BYTE[7 - bit_cnt];
    end

endmodule

`default_nettype wire

/* verif/tb_clk_gen.sv */
`default_nettype none

module tb_clk_gen
(
    output logic o_clk
);
    timeunit 1ns;
    timeprecision 100ps;

    initial
    begin
        o_clk = 1'b0;
        forever #20 o_clk = ~o_clk;     // 40 ns period
    end

endmodule

`default_nettype wire

/* verif/tb_i2c_master.sv */
`default_nettype none

module tb_i2c_master;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [6:0] SLAVE_ADDR = 7'h2C;
    localparam logic [6:0] OTHER_ADDR = 7'h13;
    localparam logic [i2c_pkg::DATA_W-1:0] READ_BYTE = 8'hA5;
    localparam int PRESCALE = 16;
    localparam int N_TRANS  = 12;
    // four times ten bits of five ticks each plus the first reset count
    localparam int TIMEOUT_CYCLES = 4 * 10 * 5 * (PRESCALE / 4 + 1) * N_TRANS
                                    + i2c_pkg::RESET_PRESCALE;

    logic                           sysclk;
    logic                           nreset;
    logic                           enable;
    logic [i2c_pkg::PRESCALE_W-1:0] prescale;
    logic [i2c_pkg::PRESCALE_W-1:0] dfsr;
    logic                           start;
    logic                           stop;
    logic                           rd;
    logic                           wr;
    logic                           ack_in;
    logic [i2c_pkg::DATA_W-1:0]     txd;
    logic                           force_low;
    logic                           done;
    logic [i2c_pkg::DATA_W-1:0]     rxd;
    logic                           ack_out;
    logic                           busy;
    logic                           arblost;
    logic                           scl_out;
    logic                           scl_oen;
    logic                           sda_out;
    logic                           sda_oen;
    logic                           slave_sda_low;
    logic [7:0]                     slave_byte;
    int                             slave_count;
    wire                            scl_bus;
    wire                            sda_bus;
    int                             mismatch_cnt;
    int                             other_cnt;
    int                             cycle_cnt;
    logic [31:0]                    rng_state;

    // open drain bus pulled up unless someone pulls low
    assign scl_bus = scl_oen;
    assign sda_bus = sda_oen & !slave_sda_low;

    tb_clk_gen u_clk (.o_clk(sysclk));

    i2c_master_top uut
    (
        .i_sysclk   (sysclk),
        .i_nReset   (nreset),
        .i_enable   (enable),
        .i_prescale (prescale),
        .i_dfsr     (dfsr),
        .i_start    (start),
        .i_stop     (stop),
        .i_read     (rd),
        .i_write    (wr),
        .i_ack_in   (ack_in),
        .i_txd      (txd),
        .i_scl      (scl_bus),
        .i_sda      (sda_bus),
        .o_done     (done),
        .o_rxd      (rxd),
        .o_ack_out  (ack_out),
        .o_busy     (busy),
        .o_arblost  (arblost),
        .o_scl      (scl_out),
        .o_scl_oen  (scl_oen),
        .o_sda      (sda_out),
        .o_sda_oen  (sda_oen)
    );

    i2c_slave_model #(.ADDR(SLAVE_ADDR), .RD_BYTE(READ_BYTE)) u_slave
    (
        .i_scl       (scl_bus),
        .i_sda       (sda_bus),
        .i_force_low (force_low),
        .o_sda_low   (slave_sda_low),
        .o_rx_byte   (slave_byte),
        .o_rx_count  (slave_count)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic compare_byte(input logic [i2c_pkg::DATA_W-1:0] got,
                                input logic [i2c_pkg::DATA_W-1:0] exp, input string what);
        if (got !== exp)
        begin
            mismatch_cnt++;
            $display("MISMATCH at %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            mismatch_cnt++;
            $display("MISMATCH at %0d ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // strobes held until the done pulse
    task automatic run_byte(input logic do_start, input logic do_stop, input logic do_read,
                            input logic do_write, input logic ack_level,
                            input logic [i2c_pkg::DATA_W-1:0] data);
        @(posedge sysclk);
        start  <= do_start;
        stop   <= do_stop;
        rd     <= do_read;
        wr     <= do_write;
        ack_in <= ack_level;
        txd    <= data;
        @(posedge sysclk);
        while (done !== 1'b1)
            @(posedge sysclk);
        start <= 1'b0;
        stop  <= 1'b0;
        rd    <= 1'b0;
        wr    <= 1'b0;
    endtask

    task automatic check_idle_after_reset();
        @(posedge sysclk);
        compare_flag(busy, 1'b0, "busy after reset");
        compare_flag(arblost, 1'b0, "arblost after reset");
        compare_flag(done, 1'b0, "done after reset");
        compare_flag(scl_oen, 1'b1, "scl enable after reset");
        compare_flag(sda_oen, 1'b1, "sda enable after reset");
        compare_flag(scl_out, 1'b1, "scl pad after reset");
        compare_flag(sda_out, 1'b1, "sda pad after reset");
        start <= 1'b1;
        wr    <= 1'b1;
        txd   <= {OTHER_ADDR, 1'b0};
        while (busy !== 1'b1)
            @(posedge sysclk);
        compare_flag(scl_out, 1'b0, "scl pad after start");     // scl held low after start
        compare_flag(sda_out, 1'b0, "sda pad after start");
        repeat (30) @(posedge sysclk);          // somewhere inside the address byte
        enable <= 1'b0;
        start  <= 1'b0;
        wr     <= 1'b0;
        repeat (2) @(posedge sysclk);
        compare_flag(scl_oen, 1'b1, "scl enable while disabled");
        compare_flag(sda_oen, 1'b1, "sda enable while disabled");
        compare_flag(scl_out, 1'b1, "scl pad while disabled");
        compare_flag(sda_out, 1'b1, "sda pad while disabled");
        compare_flag(busy, 1'b0, "busy while disabled");
        enable <= 1'b1;
    endtask

    task automatic check_address_write();
        run_byte(1'b1, 1'b0, 1'b0, 1'b1, 1'b0, {OTHER_ADDR, 1'b0});
        compare_flag(ack_out, 1'b1, "ack for unused address");
        run_byte(1'b1, 1'b0, 1'b0, 1'b1, 1'b0, {SLAVE_ADDR, 1'b0});
        compare_flag(ack_out, 1'b0, "ack for slave address");
        compare_flag(busy, 1'b1, "busy after start");
        compare_flag(arblost, 1'b0, "arblost after address");
    endtask

    task automatic check_random_writes();
        logic [i2c_pkg::DATA_W-1:0] data;
        int                         count_before;
        for (int i = 0; i < 3; i++)
        begin
            rng_state    = xorshift32(rng_state);
            data         = rng_state[i2c_pkg::DATA_W-1:0];
            count_before = slave_count;
            run_byte(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, data);
            compare_flag(ack_out, 1'b0, "ack for data byte");
            if (slave_count != count_before + 1)
            begin
                other_cnt++;
                $display("ERROR at %0d ns: slave model recorded no data byte %0d", $time, i);
            end
            else
                compare_byte(slave_byte, data, "byte seen by slave");
        end
    endtask

    task automatic check_read_with_stop();
        run_byte(1'b1, 1'b0, 1'b0, 1'b1, 1'b0, {SLAVE_ADDR, 1'b1});   // repeated start
        compare_flag(ack_out, 1'b0, "ack for read address");
        run_byte(1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 8'h00);
        compare_byte(rxd, READ_BYTE, "read data");
        compare_flag(busy, 1'b0, "busy after stop");
        compare_flag(arblost, 1'b0, "arblost after read");
    endtask

    task automatic check_arbitration_loss();
        run_byte(1'b1, 1'b0, 1'b0, 1'b1, 1'b0, {SLAVE_ADDR, 1'b0});
        compare_flag(ack_out, 1'b0, "ack before arbitration byte");
        @(posedge sysclk);
        force_low <= 1'b1;                      // another master holds sda
        run_byte(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 8'hFF);
        compare_flag(arblost, 1'b1, "arblost on contested bit");
        force_low <= 1'b0;
        @(posedge sysclk);
        enable <= 1'b0;
        @(posedge sysclk);
        enable <= 1'b1;
        @(posedge sysclk);
        compare_flag(arblost, 1'b0, "arblost after enable toggle");
        run_byte(1'b1, 1'b0, 1'b0, 1'b1, 1'b0, {SLAVE_ADDR, 1'b0});
        compare_flag(ack_out, 1'b0, "ack after recovery");
        compare_flag(busy, 1'b1, "busy after recovery");
        run_byte(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 8'h00);
        compare_flag(busy, 1'b0, "busy after final stop");
    endtask

    initial
    begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES)
        begin
            @(posedge sysclk);
            cycle_cnt++;
        end
        $display("TIMEOUT: the DUT did not respond within %0d cycles, %0d mismatches",
                 cycle_cnt, mismatch_cnt);
        $display("** FAIL **");
        $finish;
    end

    initial
    begin
        nreset       = 1'b0;
        enable       = 1'b1;
        prescale     = PRESCALE;
        dfsr         = 16'd4;
        start        = 1'b0;
        stop         = 1'b0;
        rd           = 1'b0;
        wr           = 1'b0;
        ack_in       = 1'b0;
        txd          = '0;
        force_low    = 1'b0;
        mismatch_cnt = 0;
        other_cnt    = 0;
        rng_state    = 32'hb3909f16;
        repeat (2) @(posedge sysclk);
        nreset <= 1'b1;
        check_idle_after_reset();
        check_address_write();
        check_random_writes();
        check_read_with_stop();
        check_arbitration_loss();
        @(posedge sysclk);
        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire
